//--- logic/avalon_master.sv
`timescale 1ns/10ps

module avalon_master (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  req_valid,
    output logic                  req_ready,
    input  mem_pkg::mem_req_t     req,

    output logic                  rsp_valid,
    input  logic                  rsp_ready,
    output mem_pkg::mem_rsp_t     rsp,

    output logic                  write_done,

    // avalon master
    output mem_pkg::dword_addr_t  avm_address,
    output mem_pkg::data_t        avm_writedata,
    output mem_pkg::byte_en_t     avm_byteenable,
    output logic                  avm_write,
    output logic                  avm_read,

    input  logic                  avm_waitrequest,
    input  logic                  avm_readdatavalid,
    input  mem_pkg::data_t        avm_readdata
);
    import mem_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_write,
        st_read,
        st_read_wait,
        st_respond
    } state_t;

    state_t state;
    logic   pop;

    // ------------------------------------------------------------------------
    // handshakes and command strobes
    // ------------------------------------------------------------------------

    assign req_ready  = (state == st_idle);   // one transfer at a time
    assign pop        = req_valid && req_ready;
    assign avm_write  = (state == st_write);
    assign avm_read   = (state == st_read);
    assign rsp_valid  = (state == st_respond);
    assign write_done = avm_write && !avm_waitrequest;  // bus took the write

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (pop) state <= req.write ? st_write : st_read;
                end
                st_write: begin
                    if (!avm_waitrequest) state <= st_idle;
                end
                st_read: begin
                    if (!avm_waitrequest) state <= st_read_wait;
                end
                st_read_wait: begin
                    if (avm_readdatavalid) state <= st_respond;
                end
                st_respond: begin
                    if (rsp_ready) state <= st_idle;  // held under back-pressure
                end
                default: state <= st_idle;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // command and response payload
    // ------------------------------------------------------------------------

    // loaded only at pop, so stable while waitrequest holds the command
    always_ff @(posedge clk) begin
        if (pop) begin
            avm_address    <= req.addr;
            avm_writedata  <= req.data;
            avm_byteenable <= req.be;
            rsp.off        <= req.off;
            rsp.len        <= req.len;
        end
        if (state == st_read_wait && avm_readdatavalid) begin
            rsp.data <= avm_readdata;  // raw dword
        end
    end

endmodule

//--- logic/mem_link_fifo.sv
`timescale 1ns/10ps

module mem_link_fifo #(
    parameter int link_depth = 2
) (
    input  logic              clk,
    input  logic              rst,

    input  logic              in_valid,
    output logic              in_ready,
    input  mem_pkg::mem_req_t in_req,

    output logic              out_valid,
    input  logic              out_ready,
    output mem_pkg::mem_req_t out_req
);
    import mem_pkg::*;

    localparam int ptr_w = (link_depth > 1) ? $clog2(link_depth) : 1;
    localparam int cnt_w = $clog2(link_depth + 1);

    mem_req_t         entries [link_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             push;
    logic             pop;

    // wraps at any depth, not only powers of two
    function automatic logic [ptr_w-1:0] next_ptr(logic [ptr_w-1:0] ptr);
        return (ptr == ptr_w'(link_depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign in_ready  = (count != cnt_w'(link_depth));
    assign out_valid = (count != '0);
    assign out_req   = entries[rd_ptr];  // head of queue
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= next_ptr(wr_ptr);
            if (pop)  rd_ptr <= next_ptr(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // none, or both at once
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= in_req;
        end
    end

endmodule

//--- logic/mem_pkg.sv
package mem_pkg;

    // ------------------------------------------------------------------------
    // widths with a meaning of their own
    // ------------------------------------------------------------------------

    typedef logic [31:0] addr_t;        // byte address
    typedef logic [29:0] dword_addr_t;  // address bits 31:2
    typedef logic [31:0] data_t;        // one bus dword
    typedef logic [3:0]  byte_en_t;     // lane enables
    typedef logic [1:0]  byte_off_t;    // byte within dword
    typedef logic [2:0]  access_len_t;  // 1, 2 or 4 bytes

    localparam int dword_bytes = $bits(data_t) / 8;

    // ------------------------------------------------------------------------
    // request and response records
    // ------------------------------------------------------------------------

    // one entry of the ordered request stream
    typedef struct packed {
        logic        write;  // 1 = write, 0 = read
        dword_addr_t addr;
        data_t       data;   // already placed in its lanes
        byte_en_t    be;
        byte_off_t   off;    // kept for the read return path
        access_len_t len;
    } mem_req_t;

    // raw read dword plus what is needed to align it
    typedef struct packed {
        data_t       data;
        byte_off_t   off;
        access_len_t len;
    } mem_rsp_t;

endpackage

//--- logic/mem_request_arbiter.sv
`timescale 1ns/10ps

module mem_request_arbiter (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  read_valid,
    output logic                  read_ready,
    input  mem_pkg::addr_t        read_address,
    input  mem_pkg::access_len_t  read_length,

    input  logic                  write_valid,
    output logic                  write_ready,
    input  mem_pkg::addr_t        write_address,
    input  mem_pkg::access_len_t  write_length,
    input  mem_pkg::data_t        write_data,

    output logic                  req_valid,
    output mem_pkg::mem_req_t     req,
    input  logic                  req_ready
);
    import mem_pkg::*;

    logic     armed;       // low for the first cycle out of reset
    logic     last_write;  // side served last
    logic     can_load;
    logic     write_wins;
    logic     take;
    addr_t    sel_address;
    mem_req_t next_req;

    // length mask moved up to the offset, lanes past 3 fall off
    function automatic byte_en_t lane_enable(access_len_t len, byte_off_t off);
        logic [4:0] span;
        logic [7:0] placed;
        span   = (5'd1 << len) - 5'd1;
        placed = {3'b000, span} << off;
        return placed[dword_bytes-1:0];
    endfunction

    // ------------------------------------------------------------------------
    // grant
    // ------------------------------------------------------------------------

    assign can_load    = armed && (!req_valid || req_ready);  // empty or draining
    assign write_wins  = write_valid && (!read_valid || !last_write);
    assign write_ready = can_load && write_wins;
    assign read_ready  = can_load && read_valid && !write_wins;
    assign take        = (write_valid && write_ready) || (read_valid && read_ready);

    // ------------------------------------------------------------------------
    // request formation
    // ------------------------------------------------------------------------

    always_comb begin
        sel_address    = write_ready ? write_address : read_address;
        next_req.write = write_ready;
        next_req.addr  = sel_address[31:2];
        next_req.off   = sel_address[1:0];
        next_req.len   = write_ready ? write_length : read_length;
        next_req.be    = lane_enable(next_req.len, next_req.off);
        next_req.data  = write_data << {sel_address[1:0], 3'b000};  // into its lanes
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            armed      <= 1'b0;
            req_valid  <= 1'b0;
            last_write <= 1'b0;
        end else begin
            armed <= 1'b1;
            if (take) begin
                req_valid  <= 1'b1;
                last_write <= write_ready;  // the other side wins a tie next
            end else if (req_ready) begin
                req_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            req <= next_req;  // payload only
        end
    end

endmodule

//--- logic/memory.sv
`timescale 1ns/10ps

module memory #(
    parameter int link_depth = 2
) (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  read_valid,
    output logic                  read_ready,
    input  mem_pkg::addr_t        read_address,
    input  mem_pkg::access_len_t  read_length,

    output logic                  rdata_valid,
    input  logic                  rdata_ready,
    output mem_pkg::data_t        read_data,

    input  logic                  write_valid,
    output logic                  write_ready,
    input  mem_pkg::addr_t        write_address,
    input  mem_pkg::access_len_t  write_length,
    input  mem_pkg::data_t        write_data,
    output logic                  write_done,

    // avalon master
    output mem_pkg::dword_addr_t  avm_address,
    output mem_pkg::data_t        avm_writedata,
    output mem_pkg::byte_en_t     avm_byteenable,
    output logic                  avm_write,
    output logic                  avm_read,

    input  logic                  avm_waitrequest,
    input  logic                  avm_readdatavalid,
    input  mem_pkg::data_t        avm_readdata
);
    import mem_pkg::*;

    logic     arb_valid;   // arbiter to link
    logic     arb_ready;
    mem_req_t arb_req;
    logic     link_valid;  // link to bus master
    logic     link_ready;
    mem_req_t link_req;
    logic     rsp_valid;   // bus master to aligner
    logic     rsp_ready;
    mem_rsp_t rsp;

    // ------------------------------------------------------------------------

    mem_request_arbiter arbiter_inst (
        .clk           (clk),
        .rst           (rst),
        .read_valid    (read_valid),
        .read_ready    (read_ready),
        .read_address  (read_address),
        .read_length   (read_length),
        .write_valid   (write_valid),
        .write_ready   (write_ready),
        .write_address (write_address),
        .write_length  (write_length),
        .write_data    (write_data),
        .req_valid     (arb_valid),
        .req           (arb_req),
        .req_ready     (arb_ready)
    );

    mem_link_fifo #(
        .link_depth (link_depth)
    ) link_inst (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (arb_valid),
        .in_ready  (arb_ready),
        .in_req    (arb_req),
        .out_valid (link_valid),
        .out_ready (link_ready),
        .out_req   (link_req)
    );

    // ------------------------------------------------------------------------

    avalon_master avalon_inst (
        .clk               (clk),
        .rst               (rst),
        .req_valid         (link_valid),
        .req_ready         (link_ready),
        .req               (link_req),
        .rsp_valid         (rsp_valid),
        .rsp_ready         (rsp_ready),
        .rsp               (rsp),
        .write_done        (write_done),
        .avm_address       (avm_address),
        .avm_writedata     (avm_writedata),
        .avm_byteenable    (avm_byteenable),
        .avm_write         (avm_write),
        .avm_read          (avm_read),
        .avm_waitrequest   (avm_waitrequest),
        .avm_readdatavalid (avm_readdatavalid),
        .avm_readdata      (avm_readdata)
    );

    read_align align_inst (
        .clk         (clk),
        .rst         (rst),
        .rsp_valid   (rsp_valid),
        .rsp_ready   (rsp_ready),
        .rsp         (rsp),
        .rdata_valid (rdata_valid),
        .rdata_ready (rdata_ready),
        .read_data   (read_data)
    );

endmodule

//--- logic/read_align.sv
`timescale 1ns/10ps

module read_align (
    input  logic              clk,
    input  logic              rst,

    input  logic              rsp_valid,
    output logic              rsp_ready,
    input  mem_pkg::mem_rsp_t rsp,

    output logic              rdata_valid,
    input  logic              rdata_ready,
    output mem_pkg::data_t    read_data
);
    import mem_pkg::*;

    data_t shifted;
    data_t aligned;
    logic  load;

    // requested bytes moved down to byte 0, the rest cleared
    always_comb begin
        shifted = rsp.data >> {rsp.off, 3'b000};  // lanes past 3 shift in as zero
        for (int i = 0; i < dword_bytes; i++) begin
            aligned[i*8 +: 8] = (i < rsp.len) ? shifted[i*8 +: 8] : 8'h00;
        end
    end

    assign rsp_ready = !rdata_valid || rdata_ready;  // free or emptying
    assign load      = rsp_valid && rsp_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            rdata_valid <= 1'b0;
        end else if (load) begin
            rdata_valid <= 1'b1;
        end else if (rdata_ready) begin
            rdata_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            read_data <= aligned;
        end
    end

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_memory &&
./obj_dir/Vtb_memory +verilator+error+limit+100 | tee /dev/stderr | grep -q "All tests passed" ||
exit 1

//--- tb.f
logic/mem_pkg.sv
logic/mem_request_arbiter.sv
logic/mem_link_fifo.sv
logic/avalon_master.sv
logic/read_align.sv
logic/memory.sv
verif/tb_clock.sv
verif/memory_chk.sv
verif/tb_memory.sv

//--- verif/memory_chk.sv
`timescale 1ns/10ps

module memory_chk (
    input logic                 clk,
    input logic                 rst,
    input logic                 read_ready,
    input logic                 write_ready,
    input logic                 write_done,
    input logic                 rdata_valid,
    input logic                 rdata_ready,
    input mem_pkg::data_t       read_data,
    input mem_pkg::dword_addr_t avm_address,
    input mem_pkg::data_t       avm_writedata,
    input mem_pkg::byte_en_t    avm_byteenable,
    input logic                 avm_write,
    input logic                 avm_read,
    input logic                 avm_waitrequest
);

    int failures = 0;  // read by the testbench at each test end

    // ------------------------------------------------------------------------
    // avalon side
    // ------------------------------------------------------------------------

    hold_command: assert property (@(posedge clk) disable iff (rst)
        (avm_read || avm_write) && avm_waitrequest |=>
            $stable({avm_read, avm_write, avm_address, avm_writedata, avm_byteenable}))
        else begin
            failures++;
            $error("avalon command changed while waitrequest was high");
        end

    one_command: assert property (@(posedge clk) disable iff (rst) !(avm_read && avm_write))
        else begin
            failures++;
            $error("avm_read and avm_write high together");
        end

    // ------------------------------------------------------------------------
    // response side and reset
    // ------------------------------------------------------------------------

    hold_rdata: assert property (@(posedge clk) disable iff (rst)
        rdata_valid && !rdata_ready |=> rdata_valid && $stable(read_data))
        else begin
            failures++;
            $error("read response changed while rdata_ready was low");
        end

    quiet_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !(avm_read || avm_write || rdata_valid || write_done
                         || read_ready || write_ready))
        else begin
            failures++;
            $error("control output high in the cycle after reset");
        end

endmodule

bind memory memory_chk chk (.*);

//--- verif/tb_clock.sv
`timescale 1ns/10ps

module tb_clock #(
    parameter real half_period = 4.0  // 8 ns clock
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

endmodule

//--- verif/tb_memory.sv
`timescale 1ns/10ps

module tb_memory;
    import mem_pkg::*;

    localparam int timeout_cycles = 4 * 1000;  // about 1000 cycles of stimulus

    logic        clk;
    logic        rst;
    logic        read_valid;
    logic        read_ready;
    addr_t       read_address;
    access_len_t read_length;
    logic        rdata_valid;
    logic        rdata_ready;
    data_t       read_data;
    logic        write_valid;
    logic        write_ready;
    addr_t       write_address;
    access_len_t write_length;
    data_t       write_data;
    logic        write_done;
    dword_addr_t avm_address;
    data_t       avm_writedata;
    byte_en_t    avm_byteenable;
    logic        avm_write;
    logic        avm_read;
    logic        avm_waitrequest = 1'b0;
    logic        avm_readdatavalid = 1'b0;
    data_t       avm_readdata = '0;

    logic [31:0] seed = 32'hf2ac_e2a3;
    data_t       slave_mem [64];
    data_t       ref_mem [64];   // memory as the request order leaves it
    data_t       rd_word;
    int          rd_delay = 0;
    logic        bus_order [$];  // 1 = write command
    data_t       exp_q [$];
    data_t       exp_word;
    int          errors = 0;
    int          test_start = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          writes_sent = 0;
    int          done_count = 0;
    int          bus_writes = 0;
    int          cycles = 0;

    tb_clock clock_gen (.clk(clk));

    memory #(.link_depth(2)) dut (.*);

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic data_t fill_word(int i);
        return 32'h6b43_a9b5 ^ (i * 32'h0104_1041);
    endfunction

    function automatic int error_total();
        return errors + dut.chk.failures;
    endfunction

    // ------------------------------------------------------------------------
    // avalon slave model
    // ------------------------------------------------------------------------

    always @(negedge clk) begin
        avm_readdatavalid = 1'b0;
        if (rd_delay != 0) begin
            rd_delay = rd_delay - 1;
            if (rd_delay == 0) begin
                avm_readdatavalid = 1'b1;
                avm_readdata      = rd_word;
            end
        end
        seed            = lcg_next(seed);
        avm_waitrequest = (seed[31:30] == 2'b11);  // stall one cycle in four
        if ((avm_read || avm_write) && !avm_waitrequest) begin
            bus_order.push_back(avm_write);
            if (avm_write) begin
                for (int k = 0; k < 4; k++) begin
                    if (avm_byteenable[k]) begin
                        slave_mem[avm_address[5:0]][k*8 +: 8] = avm_writedata[k*8 +: 8];
                    end
                end
                bus_writes++;
            end else begin
                rd_word  = slave_mem[avm_address[5:0]];
                seed     = lcg_next(seed);
                rd_delay = 1 + int'(seed[31:28]) % 3;  // 1 to 3 cycles
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (write_done) done_count++;
        if (rdata_valid && rdata_ready) begin
            assert (exp_q.size() != 0) else begin
                $display("read data returned with no read outstanding");
                errors++;
            end
            if (exp_q.size() != 0) begin
                exp_word = exp_q.pop_front();
                assert (read_data === exp_word) else begin
                    $display("error: read_data expected %h got %h", exp_word, read_data);
                    errors++;
                end
            end
        end
        if (cycles >= timeout_cycles) begin
            $display("timeout: run stopped after %0d cycles with work still pending", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // request drivers
    // ------------------------------------------------------------------------

    task automatic send_write(addr_t a, access_len_t len, data_t d);
        int off;
        off           = a[1:0];
        write_valid   = 1'b1;
        write_address = a;
        write_length  = len;
        write_data    = d;
        @(posedge clk);
        while (!write_ready) @(posedge clk);
        @(negedge clk);
        write_valid = 1'b0;
        writes_sent++;
        for (int k = 0; k < 4; k++) begin
            if (k >= off && k < off + len) begin
                ref_mem[a[7:2]][k*8 +: 8] = d[(k - off)*8 +: 8];
            end
        end
    endtask

    task automatic send_read(addr_t a, access_len_t len);
        data_t word;
        data_t value;
        int    off;
        read_valid   = 1'b1;
        read_address = a;
        read_length  = len;
        @(posedge clk);
        while (!read_ready) @(posedge clk);
        @(negedge clk);
        read_valid = 1'b0;
        word  = ref_mem[a[7:2]];
        off   = a[1:0];
        value = '0;
        for (int k = 0; k < 4; k++) begin
            if (k < len && off + k < 4) begin
                value[k*8 +: 8] = word[(off + k)*8 +: 8];  // past lane 3 stays zero
            end
        end
        exp_q.push_back(value);
    endtask

    task automatic end_test(string name);
        while (exp_q.size() != 0 || done_count < writes_sent) @(negedge clk);
        repeat (4) @(negedge clk);
        tests_run++;
        if (error_total() == test_start) begin
            $display("test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed", tests_run, name);
        end
        test_start = error_total();
    endtask

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------

    initial begin
        int n;
        rst           = 1'b1;
        read_valid    = 1'b0;
        read_address  = '0;
        read_length   = 3'd4;
        rdata_ready   = 1'b1;
        write_valid   = 1'b0;
        write_address = '0;
        write_length  = 3'd4;
        write_data    = '0;
        for (int i = 0; i < 64; i++) begin
            slave_mem[i] = fill_word(i);
            ref_mem[i]   = fill_word(i);
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        repeat (8) begin
            @(posedge clk);
            assert (!(avm_read || avm_write || rdata_valid || write_done)) else begin
                $display("bus or response activity before any request");
                errors++;
            end
        end
        @(negedge clk);
        end_test("idle after reset");

        n = 0;
        for (int len = 1; len <= 4; len = len * 2) begin
            for (int off = 0; off + len <= 4; off++) begin
                send_write(addr_t'(32 + 4*n + off), access_len_t'(len),
                           32'h1122_3344 + n * 32'h0f0e_0d0c);
                send_read(addr_t'(32 + 4*n), 3'd4);
                n++;
            end
        end
        end_test("write lanes");

        for (int len = 1; len <= 4; len = len * 2) begin
            for (int off = 0; off < 4; off++) begin
                send_read(addr_t'(80 + off), access_len_t'(len));  // clips from off + len > 4
            end
        end
        end_test("sub-dword reads");

        bus_order.delete();
        fork
            begin
                for (int i = 0; i < 4; i++) send_write(addr_t'(120 + i), 3'd1, 32'h0000_00a0 + i);
            end
            begin
                for (int i = 0; i < 4; i++) send_read(addr_t'(120), 3'd4);
            end
        join
        while (exp_q.size() != 0 || done_count < writes_sent) @(negedge clk);
        assert (bus_order.size() == 8) else begin
            $display("expected 8 bus commands but saw %0d", bus_order.size());
            errors++;
        end
        for (int i = 1; i < bus_order.size(); i++) begin
            assert (bus_order[i] != bus_order[i-1]) else begin
                $display("same side granted twice in a row at command %0d", i);
                errors++;
            end
        end
        end_test("fair arbitration");

        rdata_ready = 1'b0;
        for (int i = 0; i < 4; i++) send_read(addr_t'(32 + 5*i), 3'd2);
        repeat (20) @(negedge clk);  // let the queue back up
        rdata_ready = 1'b1;
        end_test("read back-pressure");

        for (int i = 0; i < 10; i++) send_write(addr_t'(160 + 4*i), 3'd4, fill_word(i) ^ 32'hffff_0000);
        while (done_count < writes_sent) @(negedge clk);
        repeat (6) @(negedge clk);
        assert (done_count == writes_sent && bus_writes == writes_sent) else begin
            $display("%0d write_done pulses and %0d bus writes for %0d writes",
                     done_count, bus_writes, writes_sent);
            errors++;
        end
        end_test("write_done per write");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_total());
        if (tests_failed == 0 && error_total() == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
